/* common/ooo_pkg.sv */
package ooo_pkg;

    // rob sizing; depth is a power of two so the pointers wrap on their own
    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = 4;

    // datapath
    localparam int XLEN      = 32;

    // architectural registers
    localparam int REG_W     = 5;
    localparam int REG_N     = 32;

    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [XLEN-1:0]  xdata_t;

    // one reorder buffer slot
    typedef struct packed {
        // destination register, unused for stores
        reg_idx_t rd;
        logic     is_store;
        // result has come back on the writeback bus
        logic     done;
        // direction assumed by fetch
        logic     pred_taken;
        // direction resolved at execute
        logic     taken;
        // correct next pc
        xdata_t   target;
        // result word
        xdata_t   data;
    } rob_entry_t;

endpackage

/* common/wb_if.sv */
`timescale 1ns/1ps

// writeback bus from the execution side into the rob
interface wb_if;

    logic              valid;
    ooo_pkg::rob_tag_t tag;
    ooo_pkg::xdata_t   data;
    // branch outcome
    logic              taken;
    ooo_pkg::xdata_t   target;

    modport producer (
        output valid,
        output tag,
        output data,
        output taken,
        output target
    );

    modport consumer (
        input valid,
        input tag,
        input data,
        input taken,
        input target
    );

endinterface

/* rob/rob.sv */
`timescale 1ns/1ps

module rob (
    input  logic                clk,
    input  logic                rst,

    // dispatch
    input  logic                disp_valid,
    input  ooo_pkg::reg_idx_t   disp_rd,
    input  logic                disp_is_store,
    input  logic                disp_pred_taken,
    output logic                disp_ready,
    output ooo_pkg::rob_tag_t   disp_tag,

    // results from execute
    wb_if.consumer              wb,

    // commit to the register file
    output logic                commit_valid,
    output ooo_pkg::reg_idx_t   commit_rd,
    output ooo_pkg::xdata_t     commit_data,
    output ooo_pkg::rob_tag_t   commit_tag,

    // store path
    output logic                store_release,
    output ooo_pkg::rob_tag_t   store_tag,

    // mispredict
    output logic                redirect_valid,
    output ooo_pkg::xdata_t     redirect_pc
);

    ooo_pkg::rob_entry_t entries [ooo_pkg::ROB_DEPTH];

    ooo_pkg::rob_tag_t        head;
    ooo_pkg::rob_tag_t        tail;
    logic [ooo_pkg::TAG_W:0]  count;

    ooo_pkg::rob_entry_t      head_entry;
    ooo_pkg::rob_tag_t        wb_offset;
    logic                     full;
    logic                     disp_fire;
    logic                     retire;
    logic                     wb_hit;

    assign full       = (count == ooo_pkg::ROB_DEPTH);
    assign head_entry = entries[head];

    // no allocation in the flush cycle as the tail is about to be reset
    assign disp_ready = !full && !redirect_valid;
    assign disp_fire  = disp_valid && disp_ready;
    assign disp_tag   = tail;

    assign retire = (count != '0) && head_entry.done;

    assign commit_valid = retire && !head_entry.is_store;
    assign commit_rd    = head_entry.rd;
    assign commit_data  = head_entry.data;
    assign commit_tag   = head;

    assign store_release = retire && head_entry.is_store;
    assign store_tag     = head;

    // the branch still commits while everything younger is dropped
    assign redirect_valid = commit_valid && (head_entry.pred_taken != head_entry.taken);
    assign redirect_pc    = head_entry.target;

    // distance from head tells whether a tag is live
    assign wb_offset = wb.tag - head;
    assign wb_hit    = ({1'b0, wb_offset} < count);

    // slot contents
    always_ff @(posedge clk) begin
        if (disp_fire) begin
            entries[tail].rd         <= disp_rd;
            entries[tail].is_store   <= disp_is_store;
            entries[tail].pred_taken <= disp_pred_taken;
            entries[tail].done       <= 1'b0;
        end
        if (wb.valid) begin
            entries[wb.tag].done   <= 1'b1;
            entries[wb.tag].data   <= wb.data;
            entries[wb.tag].taken  <= wb.taken;
            entries[wb.tag].target <= wb.target;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (redirect_valid) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (disp_fire) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + {{ooo_pkg::TAG_W{1'b0}}, disp_fire}
                           - {{ooo_pkg::TAG_W{1'b0}}, retire};
        end
    end

    // results only for tags that are still allocated
    a_wb_tag_live : assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> wb_hit
    );

    // occupancy never exceeds the depth and agrees with the pointers
    a_count_matches_pointers : assert property (
        @(posedge clk) disable iff (rst)
        (count <= ooo_pkg::ROB_DEPTH) && ((tail - head) == count[ooo_pkg::TAG_W-1:0])
    );

endmodule

/* rtl/rename_table.sv */
`timescale 1ns/1ps

module rename_table (
    input  logic               clk,
    input  logic               rst,

    // new mapping from dispatch
    input  logic               disp_fire,
    input  ooo_pkg::reg_idx_t  disp_rd,
    input  ooo_pkg::rob_tag_t  disp_tag,

    // retirement
    input  logic               commit_valid,
    input  ooo_pkg::reg_idx_t  commit_rd,
    input  ooo_pkg::rob_tag_t  commit_tag,
    input  logic               flush,

    // source operand lookup
    input  ooo_pkg::reg_idx_t  rs1,
    output logic               rs1_busy,
    output ooo_pkg::rob_tag_t  rs1_tag
);

    logic [ooo_pkg::REG_N-1:0] busy;
    ooo_pkg::rob_tag_t         tags [ooo_pkg::REG_N];

    // lookup sees state from before this cycle's dispatch
    assign rs1_busy = busy[rs1];
    assign rs1_tag  = tags[rs1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < ooo_pkg::REG_N; i++) begin
                tags[i] <= '0;
            end
        end else if (flush) begin
            busy <= '0;
        end else begin
            // only the newest writer frees the register
            if (commit_valid && busy[commit_rd] && (tags[commit_rd] == commit_tag)) begin
                busy[commit_rd] <= 1'b0;
            end
            // later assignment, so dispatch wins over commit
            if (disp_fire && (disp_rd != '0)) begin
                busy[disp_rd] <= 1'b1;
                tags[disp_rd] <= disp_tag;
            end
        end
    end

    a_x0_never_busy : assert property (
        @(posedge clk) disable iff (rst)
        !busy[0]
    );

endmodule

/* rtl/arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile (
    input  logic               clk,
    input  logic               rst,

    // commit write port
    input  logic               we,
    input  ooo_pkg::reg_idx_t  waddr,
    input  ooo_pkg::xdata_t    wdata,

    // lookup read port
    input  ooo_pkg::reg_idx_t  raddr,
    output ooo_pkg::xdata_t    rdata
);

    ooo_pkg::xdata_t regs [ooo_pkg::REG_N];

    // x0 is cleared at reset and never written
    assign rdata = regs[raddr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

/* rtl/ooo_retire_top.sv */
`timescale 1ns/1ps

module ooo_retire_top (
    input  logic               clk,
    input  logic               rst,

    input  logic               disp_valid,
    input  ooo_pkg::reg_idx_t  disp_rd,
    input  logic               disp_is_store,
    input  logic               disp_pred_taken,
    output logic               disp_ready,
    output ooo_pkg::rob_tag_t  disp_tag,

    input  logic               wb_valid,
    input  ooo_pkg::rob_tag_t  wb_tag,
    input  ooo_pkg::xdata_t    wb_data,
    input  logic               wb_taken,
    input  ooo_pkg::xdata_t    wb_target,

    input  ooo_pkg::reg_idx_t  rs1,
    output logic               rs1_busy,
    output ooo_pkg::rob_tag_t  rs1_tag,
    output ooo_pkg::xdata_t    rs1_data,

    output logic               commit_valid,
    output ooo_pkg::reg_idx_t  commit_rd,
    output ooo_pkg::xdata_t    commit_data,
    output ooo_pkg::rob_tag_t  commit_tag,
    output logic               store_release,
    output ooo_pkg::rob_tag_t  store_tag,
    output logic               redirect_valid,
    output ooo_pkg::xdata_t    redirect_pc
);

    logic disp_fire;

    wb_if i_wb ();

    assign i_wb.valid  = wb_valid;
    assign i_wb.tag    = wb_tag;
    assign i_wb.data   = wb_data;
    assign i_wb.taken  = wb_taken;
    assign i_wb.target = wb_target;

    assign disp_fire = disp_valid && disp_ready;

    rob i_rob (
        .clk, .rst,
        .disp_valid, .disp_rd, .disp_is_store, .disp_pred_taken,
        .disp_ready, .disp_tag,
        .wb             (i_wb.consumer),
        .commit_valid, .commit_rd, .commit_data, .commit_tag,
        .store_release, .store_tag,
        .redirect_valid, .redirect_pc
    );

    rename_table i_rename_table (
        .clk, .rst,
        .disp_fire, .disp_rd, .disp_tag,
        .commit_valid, .commit_rd, .commit_tag,
        .flush          (redirect_valid),
        .rs1, .rs1_busy, .rs1_tag
    );

    arch_regfile i_arch_regfile (
        .clk, .rst,
        .we             (commit_valid),
        .waddr          (commit_rd),
        .wdata          (commit_data),
        .raddr          (rs1),
        .rdata          (rs1_data)
    );

endmodule

/* sim/tb_ooo_retire.sv */
`timescale 1ns/1ps

module tb_ooo_retire;

    typedef struct packed {
        logic [31:0]     idx;
        ooo_pkg::xdata_t data;
        logic            taken;
        ooo_pkg::xdata_t target;
    } wb_cmd_t;

    logic              clk = 1'b0;
    logic              rst, disp_valid, disp_is_store, disp_pred_taken, disp_ready;
    logic              wb_valid, wb_taken, rs1_busy, commit_valid, store_release, redirect_valid;
    ooo_pkg::reg_idx_t disp_rd, rs1, commit_rd;
    ooo_pkg::rob_tag_t disp_tag, wb_tag, rs1_tag, commit_tag, store_tag;
    ooo_pkg::xdata_t   wb_data, wb_target, rs1_data, commit_data, redirect_pc;

    // expected dispatch tags in program order as indexed by the data file
    ooo_pkg::rob_tag_t tags_q [$];
    wb_cmd_t           wb_q [$];
    ooo_pkg::reg_idx_t commit_rd_q [$];
    ooo_pkg::xdata_t   commit_data_q [$];
    ooo_pkg::rob_tag_t commit_tag_q [$];
    ooo_pkg::rob_tag_t store_q [$];
    ooo_pkg::xdata_t   redirect_q [$];

    // tail model, tags are handed out in order and restart at zero after a flush
    ooo_pkg::rob_tag_t next_tag = '0;

    logic [31:0]       lfsr = 32'hb9754055;
    logic [31:0]       f [4];
    logic [1023:0]     line;
    byte               cmd;
    bit                ok;
    bit                timed_out = 1'b0;
    int                fd, errors, test_no, failed_tests, errors_before, next_retire;

    ooo_retire_top i_dut (.*);

    always #50 clk = ~clk;

    // retirement events sampled mid-cycle before the edge that performs them
    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            commit_rd_q.push_back(commit_rd);
            commit_data_q.push_back(commit_data);
            commit_tag_q.push_back(commit_tag);
        end
        if (!rst && store_release) begin
            store_q.push_back(store_tag);
        end
        if (!rst && redirect_valid) begin
            redirect_q.push_back(redirect_pc);
        end
    end

    function automatic logic next_random_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic int random_below(input int n);
        int v;
        v = 0;
        for (int i = 0; i < 8; i++) begin
            v = (v << 1) | int'(next_random_bit());
        end
        return v % n;
    endfunction

    function automatic int queued(input byte kind);
        case (kind)
            "D": return int'(disp_ready);
            "E": return commit_rd_q.size();
            "S": return store_q.size();
            default: return redirect_q.size();
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic await_event(input byte kind, output bit seen);
        int n;
        n = 0;
        while (queued(kind) == 0 && n < 200) begin
            tick();
            n++;
        end
        seen = (queued(kind) != 0);
        if (!seen) begin
            $display("timeout: nothing arrived for command %c within 200 cycles", kind);
            timed_out = 1'b1;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // one writeback per cycle in shuffled group order
    task automatic send_writebacks();
        wb_cmd_t c;
        int j;
        for (int i = wb_q.size() - 1; i > 0; i--) begin
            j = random_below(i + 1);
            c = wb_q[i];
            wb_q[i] = wb_q[j];
            wb_q[j] = c;
        end
        foreach (wb_q[i]) begin
            wb_valid  = 1'b1;
            wb_tag    = tags_q[wb_q[i].idx];
            wb_data   = wb_q[i].data;
            wb_taken  = wb_q[i].taken;
            wb_target = wb_q[i].target;
            tick();
        end
        wb_valid = 1'b0;
        wb_q.delete();
    endtask

    initial begin
        rst = 1'b1;
        disp_valid = 1'b0;
        disp_rd = '0;
        disp_is_store = 1'b0;
        disp_pred_taken = 1'b0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        wb_taken = 1'b0;
        wb_target = '0;
        rs1 = '0;
        repeat (8) begin
            tick();
        end
        rst = 1'b0;
        fd = $fopen("sim/ooo_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/ooo_testdata.txt");
            errors++;
        end
        while (fd != 0 && !timed_out && $fscanf(fd, " %c", cmd) == 1) begin
            if (cmd != "W" && wb_q.size() != 0) begin
                send_writebacks();
            end
            case (cmd)
                "#": void'($fgets(line, fd));
                "W": begin
                    void'($fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]));
                    wb_q.push_back({f[0], f[1], f[2][0], f[3]});
                end
                "D": begin
                    void'($fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]));
                    for (int k = 0; k < f[3] && !timed_out; k++) begin
                        await_event("D", ok);
                        if (ok) begin
                            disp_valid      = 1'b1;
                            disp_rd         = f[0][4:0];
                            disp_is_store   = f[1][0];
                            disp_pred_taken = f[2][0];
                            compare("disp_tag", 32'(disp_tag), 32'(next_tag));
                            tags_q.push_back(next_tag);
                            next_tag++;
                            tick();
                            disp_valid = 1'b0;
                        end
                    end
                end
                "E": begin
                    void'($fscanf(fd, "%h %h", f[0], f[1]));
                    await_event("E", ok);
                    if (ok) begin
                        compare("commit_rd", 32'(commit_rd_q.pop_front()), f[0]);
                        compare("commit_data", commit_data_q.pop_front(), f[1]);
                        compare("commit_tag", 32'(commit_tag_q.pop_front()),
                                32'(tags_q[next_retire]));
                        next_retire++;
                    end
                end
                "S": begin
                    void'($fscanf(fd, "%h", f[0]));
                    await_event("S", ok);
                    if (ok) begin
                        compare("store_tag", 32'(store_q.pop_front()), 32'(tags_q[f[0]]));
                        next_retire = int'(f[0]) + 1;
                    end
                end
                "R": begin
                    void'($fscanf(fd, "%h", f[0]));
                    await_event("R", ok);
                    if (ok) begin
                        compare("redirect_pc", redirect_q.pop_front(), f[0]);
                        // younger entries are gone and the tail restarts at zero
                        next_tag = '0;
                        next_retire = tags_q.size();
                    end
                end
                "L": begin
                    void'($fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]));
                    rs1 = f[0][4:0];
                    #1;
                    compare("rs1_busy", 32'(rs1_busy), f[1]);
                    if (f[1][0]) begin
                        compare("rs1_tag", 32'(rs1_tag), 32'(tags_q[f[2]]));
                    end
                    compare("rs1_data", rs1_data, f[3]);
                end
                "F": begin
                    compare("disp_ready", 32'(disp_ready), 32'd0);
                    disp_valid = 1'b1;
                    repeat (4) begin
                        tick();
                    end
                    disp_valid = 1'b0;
                    compare("disp_tag", 32'(disp_tag), 32'(next_tag));
                end
                "T": begin
                    repeat (4) begin
                        tick();
                    end
                    if (commit_rd_q.size() + store_q.size() + redirect_q.size() != 0) begin
                        $display("unexpected commit, store release or redirect in test %0d",
                                 test_no + 1);
                        errors++;
                    end
                    commit_rd_q.delete();
                    commit_data_q.delete();
                    commit_tag_q.delete();
                    store_q.delete();
                    redirect_q.delete();
                    test_no++;
                    if (errors == errors_before) begin
                        $display("test %0d passed", test_no);
                    end else begin
                        $display("test %0d failed with %0d errors", test_no,
                                 errors - errors_before);
                        failed_tests++;
                    end
                    errors_before = errors;
                end
                default: begin
                    $display("unknown command %c in the data file", cmd);
                    errors++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("%0d tests, %0d failed, %0d errors", test_no, failed_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sim/ooo_testdata.txt */
# D rd store pred count | W index data taken target | E rd data | S index | R pc
# L reg busy index data | F full, held dispatch refused | T end of test; hex, index = dispatch no.
D 0a 0 0 3
W 2 cccc0002 0 0
W 0 aaaa0000 0 0
W 1 bbbb0001 0 0
E 0a aaaa0000
E 0a bbbb0001
E 0a cccc0002
T
D 00 1 0 1
D 00 0 0 1
W 3 deadbeef 0 0
W 4 00000044 0 0
S 3
E 00 00000044
L 00 0 0 00000000
T
D 03 0 0 2
L 03 1 6 00000000
W 5 33330005 0 0
E 03 33330005
L 03 1 6 33330005
W 6 33330006 0 0
E 03 33330006
L 03 0 0 33330006
T
D 01 0 1 10
F
W 7 11110007 1 00000100
E 01 11110007
D 02 0 0 1
T
W 8 11110008 0 00000400
E 01 11110008
R 00000400
L 01 0 0 11110008
L 02 0 0 00000000
D 01 0 0 10
F
T

/* sim.f */
common/ooo_pkg.sv
common/wb_if.sv
rob/rob.sv
rtl/rename_table.sv
rtl/arch_regfile.sv
rtl/ooo_retire_top.sv
sim/tb_ooo_retire.sv

/* Makefile */
# Verilator build and run of the ROB retirement testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, fail on a failing run"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module tb_ooo_retire -Mdir obj_dir
	./obj_dir/Vtb_ooo_retire > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
